// ==== compile.f ====
+incdir+hw
hw/video_timing_pkg.sv
hw/switch_sampler.sv
hw/switch_debouncer.sv
hw/mode_select.sv
hw/raster_counter.sv
hw/sync_output.sv
hw/video_timing_top.sv
verif/video_timing_props.sv
verif/tb_video_timing.sv

// ==== hw/mode_select.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "video_timing_params.svh"

module mode_select (
	input  wire                             clk50m_bufg,
	input  wire                             RSTBTN,
	input  video_timing_pkg::sw_code_t      settled,
	output video_timing_pkg::video_timing_t timing,
	output logic                            mode_restart
);

	video_timing_pkg::sw_code_t  code_q;
	video_timing_pkg::video_mode_e mode;
	logic                        init_pending;   // Forces one restart out of reset

	// Pack eight lengths and the polarity bit
	function automatic video_timing_pkg::video_timing_t pack_timing(
		input int ha, input int hf, input int hs, input int hb,
		input int va, input int vf, input int vs, input int vb,
		input logic neg
	);
		pack_timing.h_active     = video_timing_pkg::coord_t'(ha);
		pack_timing.h_front      = video_timing_pkg::coord_t'(hf);
		pack_timing.h_sync       = video_timing_pkg::coord_t'(hs);
		pack_timing.h_back       = video_timing_pkg::coord_t'(hb);
		pack_timing.v_active     = video_timing_pkg::coord_t'(va);
		pack_timing.v_front      = video_timing_pkg::coord_t'(vf);
		pack_timing.v_sync       = video_timing_pkg::coord_t'(vs);
		pack_timing.v_back       = video_timing_pkg::coord_t'(vb);
		pack_timing.neg_polarity = neg;
	endfunction

	////////////////////////////////////////
	// Code register and restart pulse
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			code_q       <= `SW_HDTV720P;   // 720p until switches settle
			init_pending <= 1'b1;
			mode_restart <= 1'b0;
		end else begin
			code_q       <= settled;
			init_pending <= 1'b0;
			mode_restart <= init_pending | (settled != code_q);
		end
	end

	// Switch code to format, unlisted codes fall back to 720p
	always_comb begin
		case (code_q)
			`SW_VGA:    mode = video_timing_pkg::MODE_VGA;
			`SW_SVGA:   mode = video_timing_pkg::MODE_SVGA;
			`SW_XGA:    mode = video_timing_pkg::MODE_XGA;
			`SW_SXGA:   mode = video_timing_pkg::MODE_SXGA;
			`SW_CAMERA: mode = video_timing_pkg::MODE_CAMERA;
			default:    mode = video_timing_pkg::MODE_HDTV720P;
		endcase
	end

	// Format to timing set
	always_comb begin
		case (mode)
			video_timing_pkg::MODE_VGA: timing = pack_timing(
				`HPIXELS_VGA, `HFNPRCH_VGA, `HSYNCPW_VGA, `HBKPRCH_VGA,
				`VLINES_VGA, `VFNPRCH_VGA, `VSYNCPW_VGA, `VBKPRCH_VGA, `NEGSYNC_VGA);
			video_timing_pkg::MODE_SVGA: timing = pack_timing(
				`HPIXELS_SVGA, `HFNPRCH_SVGA, `HSYNCPW_SVGA, `HBKPRCH_SVGA,
				`VLINES_SVGA, `VFNPRCH_SVGA, `VSYNCPW_SVGA, `VBKPRCH_SVGA, `NEGSYNC_SVGA);
			video_timing_pkg::MODE_XGA: timing = pack_timing(
				`HPIXELS_XGA, `HFNPRCH_XGA, `HSYNCPW_XGA, `HBKPRCH_XGA,
				`VLINES_XGA, `VFNPRCH_XGA, `VSYNCPW_XGA, `VBKPRCH_XGA, `NEGSYNC_XGA);
			video_timing_pkg::MODE_SXGA: timing = pack_timing(
				`HPIXELS_SXGA, `HFNPRCH_SXGA, `HSYNCPW_SXGA, `HBKPRCH_SXGA,
				`VLINES_SXGA, `VFNPRCH_SXGA, `VSYNCPW_SXGA, `VBKPRCH_SXGA, `NEGSYNC_SXGA);
			video_timing_pkg::MODE_CAMERA: timing = pack_timing(
				`HPIXELS_CAMERA, `HFNPRCH_CAMERA, `HSYNCPW_CAMERA, `HBKPRCH_CAMERA,
				`VLINES_CAMERA, `VFNPRCH_CAMERA, `VSYNCPW_CAMERA, `VBKPRCH_CAMERA,
				`NEGSYNC_CAMERA);
			default: timing = pack_timing(
				`HPIXELS_HDTV720P, `HFNPRCH_HDTV720P, `HSYNCPW_HDTV720P, `HBKPRCH_HDTV720P,
				`VLINES_HDTV720P, `VFNPRCH_HDTV720P, `VSYNCPW_HDTV720P, `VBKPRCH_HDTV720P,
				`NEGSYNC_HDTV720P);
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/raster_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module raster_counter (
	input  wire                             clk50m_bufg,
	input  wire                             RSTBTN,
	input  video_timing_pkg::video_timing_t timing,
	input  wire                             mode_restart,   // Clears both counters
	output video_timing_pkg::raster_t       raster
);

	video_timing_pkg::coord_t hcount_q, vcount_q;
	video_timing_pkg::coord_t h_sync_start, h_sync_end, h_last;
	video_timing_pkg::coord_t v_sync_start, v_sync_end, v_last;

	////////////////////////////////////////
	// Region boundaries from the lengths
	////////////////////////////////////////
	always_comb begin
		h_sync_start = timing.h_active + timing.h_front;
		h_sync_end   = h_sync_start + timing.h_sync;
		h_last       = h_sync_end + timing.h_back - 1'b1;   // Final pixel of a line
		v_sync_start = timing.v_active + timing.v_front;
		v_sync_end   = v_sync_start + timing.v_sync;
		v_last       = v_sync_end + timing.v_back - 1'b1;   // Final line of a frame
	end

	// Horizontal and vertical counters
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || mode_restart) begin
			hcount_q <= '0;
			vcount_q <= '0;
		end else if (hcount_q >= h_last) begin
			hcount_q <= '0;                  // End of line
			if (vcount_q >= v_last)
				vcount_q <= '0;              // End of frame
			else
				vcount_q <= vcount_q + 1'b1;
		end else begin
			hcount_q <= hcount_q + 1'b1;
		end
	end

	// Raw flags, active high
	always_comb begin
		raster.hcount = hcount_q;
		raster.vcount = vcount_q;
		raster.hblank = (hcount_q >= timing.h_active);
		raster.vblank = (vcount_q >= timing.v_active);
		raster.hsync  = (hcount_q >= h_sync_start) && (hcount_q < h_sync_end);
		raster.vsync  = (vcount_q >= v_sync_start) && (vcount_q < v_sync_end);
	end

endmodule

`default_nettype wire

// ==== hw/switch_debouncer.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "video_timing_params.svh"

module switch_debouncer #(
	parameter logic RESET_LEVEL = 1'b0   // Level held until the first settle
) (
	input  wire  clk50m_bufg,
	input  wire  RSTBTN,
	input  wire  sample_in,      // Already synchronized
	input  wire  sample_tick,
	output logic settled
);

	localparam int CNT_W = $clog2(`DEBOUNCE_TICKS + 1);

	logic [CNT_W-1:0] diff_cnt;   // Consecutive ticks that disagree
	logic             last_diff;

	// Final disagreeing tick of a run
	assign last_diff = (diff_cnt == CNT_W'(`DEBOUNCE_TICKS - 1));

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			settled  <= RESET_LEVEL;
			diff_cnt <= '0;
		end else if (sample_tick) begin
			if (sample_in == settled) begin
				diff_cnt <= '0;                // Agreeing sample restarts the run
			end else if (last_diff) begin
				settled  <= sample_in;         // Accept new level
				diff_cnt <= '0;
			end else begin
				diff_cnt <= diff_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/switch_sampler.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "video_timing_params.svh"

module switch_sampler (
	input  wire                       clk50m_bufg,
	input  wire                       RSTBTN,
	input  video_timing_pkg::sw_code_t sw,          // Straight from the pins
	output video_timing_pkg::sw_code_t sw_sync,
	output logic                      sample_tick   // One cycle per sample period
);

	localparam int DIV_W = $clog2(`DEBOUNCE_TICK_CYCLES);

	video_timing_pkg::sw_code_t sw_meta;   // First flop, may go metastable
	logic [DIV_W-1:0] div_cnt;

	// Two flop synchronizer
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta <= '0;
			sw_sync <= '0;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
		end
	end

	// Prescaler for the debounce sample tick
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			div_cnt     <= '0;
			sample_tick <= 1'b0;
		end else if (div_cnt == DIV_W'(`DEBOUNCE_TICK_CYCLES - 1)) begin
			div_cnt     <= '0;
			sample_tick <= 1'b1;
		end else begin
			div_cnt     <= div_cnt + 1'b1;
			sample_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== hw/sync_output.sv ====
`timescale 1ns/1ns
`default_nettype none

module sync_output (
	input  wire                       clk50m_bufg,
	input  wire                       RSTBTN,
	input  video_timing_pkg::raster_t raster,
	input  wire                       neg_polarity,
	output logic                      hsync,
	output logic                      vsync,
	output logic                      de,
	output video_timing_pkg::coord_t  hcount,
	output video_timing_pkg::coord_t  vcount
);

	logic hsync_q, vsync_q, de_q;          // First stage
	video_timing_pkg::coord_t hcount_q, vcount_q;

	// Two stage pipeline, polarity applied in the first stage
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync_q  <= 1'b0;
			vsync_q  <= 1'b0;
			de_q     <= 1'b0;
			hcount_q <= '0;
			vcount_q <= '0;
			hsync    <= 1'b0;
			vsync    <= 1'b0;
			de       <= 1'b0;
			hcount   <= '0;
			vcount   <= '0;
		end else begin
			hsync_q  <= raster.hsync ^ neg_polarity;
			vsync_q  <= raster.vsync ^ neg_polarity;
			de_q     <= !raster.hblank && !raster.vblank;   // Active area only
			hcount_q <= raster.hcount;
			vcount_q <= raster.vcount;
			hsync    <= hsync_q;
			vsync    <= vsync_q;
			de       <= de_q;
			hcount   <= hcount_q;   // Counts kept aligned with de
			vcount   <= vcount_q;
		end
	end

endmodule

`default_nettype wire

// ==== hw/video_timing_params.svh ====
`ifndef VIDEO_TIMING_PARAMS_SVH
`define VIDEO_TIMING_PARAMS_SVH

////////////////////////////////////////
// Format timings, pixels and lines
////////////////////////////////////////

// 640x480@60
`define HPIXELS_VGA       640
`define HFNPRCH_VGA       16
`define HSYNCPW_VGA       96
`define HBKPRCH_VGA       48
`define VLINES_VGA        480
`define VFNPRCH_VGA       11
`define VSYNCPW_VGA       2
`define VBKPRCH_VGA       31
`define NEGSYNC_VGA       1'b1    // Negative sync

// 800x600@60
`define HPIXELS_SVGA      800
`define HFNPRCH_SVGA      40
`define HSYNCPW_SVGA      128
`define HBKPRCH_SVGA      88
`define VLINES_SVGA       600
`define VFNPRCH_SVGA      1
`define VSYNCPW_SVGA      4
`define VBKPRCH_SVGA      23
`define NEGSYNC_SVGA      1'b0

// 1024x768@60
`define HPIXELS_XGA       1024
`define HFNPRCH_XGA       24
`define HSYNCPW_XGA       136
`define HBKPRCH_XGA       160
`define VLINES_XGA        768
`define VFNPRCH_XGA       3
`define VSYNCPW_XGA       6
`define VBKPRCH_XGA       29
`define NEGSYNC_XGA       1'b1    // Negative sync

// 1280x720@60, also the fallback format
`define HPIXELS_HDTV720P  1280
`define HFNPRCH_HDTV720P  110
`define HSYNCPW_HDTV720P  40
`define HBKPRCH_HDTV720P  220
`define VLINES_HDTV720P   720
`define VFNPRCH_HDTV720P  5
`define VSYNCPW_HDTV720P  5
`define VBKPRCH_HDTV720P  20
`define NEGSYNC_HDTV720P  1'b0

// 1280x1024@60
`define HPIXELS_SXGA      1280
`define HFNPRCH_SXGA      48
`define HSYNCPW_SXGA      112
`define HBKPRCH_SXGA      248
`define VLINES_SXGA       1024
`define VFNPRCH_SXGA      1
`define VSYNCPW_SXGA      3
`define VBKPRCH_SXGA      38
`define NEGSYNC_SXGA      1'b0

// Camera variant of 720p, shorter sync
`define HPIXELS_CAMERA    1280
`define HFNPRCH_CAMERA    110
`define HSYNCPW_CAMERA    39
`define HBKPRCH_CAMERA    220
`define VLINES_CAMERA     720
`define VFNPRCH_CAMERA    4
`define VSYNCPW_CAMERA    4
`define VBKPRCH_CAMERA    22
`define NEGSYNC_CAMERA    1'b0

////////////////////////////////////////
// Switch codes and debounce
////////////////////////////////////////
`define SW_VGA            4'b0000
`define SW_SVGA           4'b0001
`define SW_XGA            4'b0011
`define SW_HDTV720P       4'b0010
`define SW_SXGA           4'b1000
`define SW_CAMERA         4'b1001

`define DEBOUNCE_TICK_CYCLES  64   // Clocks per sample tick
`define DEBOUNCE_TICKS        4    // Agreeing ticks to accept a level
`define NUM_SWITCHES          4

`endif

// ==== hw/video_timing_pkg.sv ====
`default_nettype none
`include "video_timing_params.svh"

package video_timing_pkg;

	////////////////////////////////////////
	// Scalar types
	////////////////////////////////////////
	typedef logic [10:0] coord_t;                  // Pixel or line count
	typedef logic [`NUM_SWITCHES-1:0] sw_code_t;   // Slide switch code

	// Decoded display format
	typedef enum logic [2:0] {
		MODE_VGA,
		MODE_SVGA,
		MODE_XGA,
		MODE_HDTV720P,
		MODE_SXGA,
		MODE_CAMERA
	} video_mode_e;

	////////////////////////////////////////
	// Structs
	////////////////////////////////////////

	// Lengths of each raster region, 89 bits
	typedef struct packed {
		coord_t h_active;
		coord_t h_front;
		coord_t h_sync;
		coord_t h_back;
		coord_t v_active;
		coord_t v_front;
		coord_t v_sync;
		coord_t v_back;
		logic   neg_polarity;   // 1 = active low syncs
	} video_timing_t;

	// Raw raster position and flags, 26 bits
	typedef struct packed {
		coord_t hcount;
		coord_t vcount;
		logic   hblank;
		logic   vblank;
		logic   hsync;          // Active high, before polarity
		logic   vsync;
	} raster_t;

endpackage

`default_nettype wire

// ==== hw/video_timing_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "video_timing_params.svh"

module video_timing_top (
	input  wire                       clk50m_bufg,
	input  wire                       RSTBTN,
	input  video_timing_pkg::sw_code_t sw,         // Format select switches
	output logic                      hsync,
	output logic                      vsync,
	output logic                      de,
	output video_timing_pkg::coord_t  hcount,
	output video_timing_pkg::coord_t  vcount
);

	localparam video_timing_pkg::sw_code_t RESET_CODE = `SW_HDTV720P;

	video_timing_pkg::sw_code_t      sw_sync;
	video_timing_pkg::sw_code_t      settled;
	video_timing_pkg::video_timing_t timing;
	video_timing_pkg::raster_t       raster;
	logic                            sample_tick;
	logic                            mode_restart;

	////////////////////////////////////////
	// Switch path
	////////////////////////////////////////
	switch_sampler u_sampler (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.sw_sync     (sw_sync),
		.sample_tick (sample_tick)
	);

	// One debouncer per switch, each reset to the 720p code bit
	for (genvar i = 0; i < `NUM_SWITCHES; i++) begin : g_deb
		switch_debouncer #(.RESET_LEVEL(RESET_CODE[i])) u_deb (
			.clk50m_bufg (clk50m_bufg),
			.RSTBTN      (RSTBTN),
			.sample_in   (sw_sync[i]),
			.sample_tick (sample_tick),
			.settled     (settled[i])
		);
	end

	mode_select u_mode (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.settled      (settled),
		.timing       (timing),
		.mode_restart (mode_restart)
	);

	////////////////////////////////////////
	// Raster and output stage
	////////////////////////////////////////
	raster_counter u_raster (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.timing       (timing),
		.mode_restart (mode_restart),
		.raster       (raster)
	);

	sync_output u_out (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.raster       (raster),
		.neg_polarity (timing.neg_polarity),
		.hsync        (hsync),
		.vsync        (vsync),
		.de           (de),
		.hcount       (hcount),
		.vcount       (vcount)
	);

endmodule

`default_nettype wire

// ==== verif/tb_video_timing.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "video_timing_params.svh"

module tb_video_timing;

	////////////////////////////////////////
	// Expected totals from the format table
	////////////////////////////////////////
	localparam int LINE_VGA  = `HPIXELS_VGA + `HFNPRCH_VGA + `HSYNCPW_VGA + `HBKPRCH_VGA;
	localparam int LINE_SVGA = `HPIXELS_SVGA + `HFNPRCH_SVGA + `HSYNCPW_SVGA + `HBKPRCH_SVGA;
	localparam int LINE_XGA  = `HPIXELS_XGA + `HFNPRCH_XGA + `HSYNCPW_XGA + `HBKPRCH_XGA;
	localparam int LINE_SXGA = `HPIXELS_SXGA + `HFNPRCH_SXGA + `HSYNCPW_SXGA + `HBKPRCH_SXGA;
	localparam int LINE_CAMERA = `HPIXELS_CAMERA + `HFNPRCH_CAMERA + `HSYNCPW_CAMERA
		+ `HBKPRCH_CAMERA;
	localparam int LINE_HDTV720P = `HPIXELS_HDTV720P + `HFNPRCH_HDTV720P + `HSYNCPW_HDTV720P
		+ `HBKPRCH_HDTV720P;
	localparam int FRAME_HDTV720P = LINE_HDTV720P * (`VLINES_HDTV720P + `VFNPRCH_HDTV720P
		+ `VSYNCPW_HDTV720P + `VBKPRCH_HDTV720P);

	// Worst case switch settle, plus restart and output pipeline
	localparam int SETTLE_CYCLES = 2 + (`DEBOUNCE_TICKS + 1) * `DEBOUNCE_TICK_CYCLES + 8;
	localparam int GLITCH_CYCLES = (`DEBOUNCE_TICKS - 1) * `DEBOUNCE_TICK_CYCLES - 8;   // < 4 ticks
	localparam int TIMEOUT_CYCLES = 2 * (9 * SETTLE_CYCLES + GLITCH_CYCLES + FRAME_HDTV720P
		+ `VSYNCPW_HDTV720P * LINE_HDTV720P
		+ 2 * (LINE_VGA + LINE_SVGA + LINE_XGA + LINE_SXGA + LINE_CAMERA + 3 * LINE_HDTV720P));

	logic                       clk50m_bufg;
	logic                       RSTBTN;
	video_timing_pkg::sw_code_t sw;
	logic                       hsync, vsync, de;
	video_timing_pkg::coord_t   hcount, vcount;
	int cycle_count;
	int error_count;
	int tests_run;
	int tests_failed;

	video_timing_top dut0 (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.hcount      (hcount),
		.vcount      (vcount)
	);

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg;   // 50 MHz
	end

	// Watchdog
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk50m_bufg);
			cycle_count++;
		end
		$display("Timeout: tests still running after %0d cycles", cycle_count);
		$display("Test failed");
		$finish;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	function automatic logic probe(input int which);
		case (which)
			0:       probe = hsync;
			1:       probe = vsync;
			default: probe = de;
		endcase
	endfunction

	task automatic check_value(input string what, input int got, input int expected);
		assert (got == expected)
		else begin
			$display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
			error_count++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d checks wrong", name, error_count - errors_before);
		end
	endtask

	task automatic set_switches(input video_timing_pkg::sw_code_t code);
		@(posedge clk50m_bufg);
		sw <= code;
	endtask

	// Stops on the first cycle of an active pulse, sampled mid cycle
	task automatic wait_edge(input int which, input logic active);
		logic prev;
		logic cur;
		@(negedge clk50m_bufg);
		prev = probe(which);
		cur  = prev;
		while (!(prev != active && cur == active)) begin
			prev = cur;
			@(negedge clk50m_bufg);
			cur = probe(which);
		end
	endtask

	// Call right after wait_edge
	task automatic pulse_width(input int which, input logic active, output int width);
		width = 1;
		@(negedge clk50m_bufg);
		while (probe(which) == active) begin
			width++;
			@(negedge clk50m_bufg);
		end
	endtask

	// Cycles where hcount does not step by one, line wrap included
	task automatic count_hcount_jumps(input int cycles, input int line_total,
		output int jumps);
		int prev;
		jumps = 0;
		@(negedge clk50m_bufg);
		prev = hcount;
		repeat (cycles) begin
			@(negedge clk50m_bufg);
			if (hcount != (prev + 1) % line_total)
				jumps++;
			prev = hcount;
		end
	endtask

	// One hsync period: length, pulse width and de cycles
	task automatic measure_line(input logic active, output int period, output int width,
		output int pixels);
		logic prev;
		logic cur;
		logic done;
		wait_edge(0, active);
		period = 1;
		width  = 1;
		pixels = de;
		prev   = active;
		done   = 1'b0;
		while (!done) begin
			@(negedge clk50m_bufg);
			cur = hsync;
			if (prev != active && cur == active) begin
				done = 1'b1;                     // Next line starts
			end else begin
				period++;
				if (cur == active) width++;
				if (de) pixels++;
			end
			prev = cur;
		end
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////
	task automatic test_reset_defaults();
		int errors_before;
		errors_before = error_count;
		repeat (7) @(posedge clk50m_bufg);   // Reset high since time 0
		@(negedge clk50m_bufg);
		check_value("de in reset", de, 0);
		check_value("hsync in reset", hsync, 0);
		check_value("vsync in reset", vsync, 0);
		check_value("hcount in reset", hcount, 0);
		check_value("vcount in reset", vcount, 0);
		@(posedge clk50m_bufg);
		RSTBTN <= 1'b0;                      // 8th edge samples reset high
		finish_test("reset_defaults", errors_before);
	endtask

	// Line total, sync width and polarity, active pixels
	task automatic check_format(input string name, input video_timing_pkg::sw_code_t code,
		input int pixels_exp, input int line_exp, input int sync_exp, input logic neg);
		int errors_before;
		int period;
		int width;
		int pixels;
		errors_before = error_count;
		set_switches(code);
		repeat (SETTLE_CYCLES) @(posedge clk50m_bufg);
		measure_line(!neg, period, width, pixels);   // Wrong polarity shows as wrong width
		check_value({name, " line total"}, period, line_exp);
		check_value({name, " hsync width"}, width, sync_exp);
		check_value({name, " de per line"}, pixels, pixels_exp);
		finish_test(name, errors_before);
	endtask

	task automatic test_vertical_720p();
		int errors_before;
		int period;
		int width;
		int pixels;
		errors_before = error_count;
		set_switches(`SW_HDTV720P);
		repeat (SETTLE_CYCLES) @(posedge clk50m_bufg);
		measure_line(1'b1, period, width, pixels);
		check_value("720p hsync width", width, `HSYNCPW_HDTV720P);
		wait_edge(1, 1'b1);                          // Positive vsync
		check_value("720p vcount at vsync", vcount, `VLINES_HDTV720P + `VFNPRCH_HDTV720P);
		check_value("720p hcount at vsync", hcount, 0);
		pulse_width(1, 1'b1, width);
		check_value("720p vsync width", width, `VSYNCPW_HDTV720P * LINE_HDTV720P);
		finish_test("vertical_720p", errors_before);
	endtask

	// Short VGA glitch while in 720p, raster must run on without a restart
	task automatic test_glitch();
		int errors_before;
		int period;
		int width;
		int pixels;
		int jumps;
		errors_before = error_count;
		jumps = 0;
		fork
			begin
				set_switches(`SW_VGA);
				repeat (GLITCH_CYCLES) @(posedge clk50m_bufg);
				sw <= `SW_HDTV720P;
				repeat (SETTLE_CYCLES) @(posedge clk50m_bufg);
			end
			count_hcount_jumps(GLITCH_CYCLES + SETTLE_CYCLES, LINE_HDTV720P, jumps);
		join
		check_value("glitch hcount jumps", jumps, 0);
		measure_line(1'b1, period, width, pixels);
		check_value("glitch line total", period, LINE_HDTV720P);
		check_value("glitch hsync width", width, `HSYNCPW_HDTV720P);
		finish_test("debounce_glitch", errors_before);
	endtask

	initial begin
		RSTBTN       = 1'b1;
		sw           = `SW_HDTV720P;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;

		test_reset_defaults();
		check_format("vga_horizontal", `SW_VGA, `HPIXELS_VGA, LINE_VGA, `HSYNCPW_VGA,
			`NEGSYNC_VGA);
		test_vertical_720p();
		test_glitch();
		check_format("svga", `SW_SVGA, `HPIXELS_SVGA, LINE_SVGA, `HSYNCPW_SVGA, `NEGSYNC_SVGA);
		check_format("xga", `SW_XGA, `HPIXELS_XGA, LINE_XGA, `HSYNCPW_XGA, `NEGSYNC_XGA);
		check_format("sxga", `SW_SXGA, `HPIXELS_SXGA, LINE_SXGA, `HSYNCPW_SXGA, `NEGSYNC_SXGA);
		check_format("camera", `SW_CAMERA, `HPIXELS_CAMERA, LINE_CAMERA, `HSYNCPW_CAMERA,
			`NEGSYNC_CAMERA);
		// From camera, so the fallback differs by one pixel and one sync cycle
		check_format("unlisted_code", 4'b0111, `HPIXELS_HDTV720P, LINE_HDTV720P,
			`HSYNCPW_HDTV720P, `NEGSYNC_HDTV720P);

		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
			error_count);
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/video_timing_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module video_timing_props (
	input wire                             clk50m_bufg,
	input wire                             RSTBTN,
	input wire                             mode_restart,
	input wire                             de,
	input video_timing_pkg::raster_t       raster,
	input video_timing_pkg::video_timing_t timing
);

	video_timing_pkg::coord_t line_total;   // Pixels per line, current format

	assign line_total = timing.h_active + timing.h_front + timing.h_sync + timing.h_back;

	// Restart is a single cycle pulse
	a_restart_pulse: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		mode_restart |=> !mode_restart)
		else $error("mode_restart held for more than one cycle");

	// de trails the raw flags by two stages
	a_de_blank: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		de |-> !$past(raster.hblank, 2))
		else $error("de high during horizontal blank");

	// Counter never runs past the line end, except on the restart cycle
	a_hcount_range: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!mode_restart |-> raster.hcount < line_total)
		else $error("hcount beyond line total");

endmodule

bind video_timing_top video_timing_props props0 (
	.clk50m_bufg  (clk50m_bufg),
	.RSTBTN       (RSTBTN),
	.mode_restart (mode_restart),
	.de           (de),
	.raster       (raster),
	.timing       (timing)
);

`default_nettype wire
